// File: source/gprSizePkg.sv
`default_nettype none

// Sizes of the register file and the value types built on them
package gprSizePkg;

	localparam int dataWidth = 64;
	localparam int gprCount = 32;
	localparam int laneCount = 3;		// Write lanes, one bank each
	localparam int readPortCount = 6;	// Two per lane
	localparam int immWidth = 33;

	// Index into a bank, derived from the register count
	localparam int gprIndexWidth = $clog2(gprCount);

	typedef logic [dataWidth-1:0] regValueT;
	typedef logic [immWidth-1:0] immValueT;	// Decoded immediate, top bit is sign

endpackage

`default_nettype wire

// File: source/gprIdPkg.sv
`default_nettype none

package gprIdPkg;

	localparam int regIdWidth = 6;

	// Ids 0 to 31 are architectural, 32 and up are special
	typedef logic [regIdWidth-1:0] regIdT;

	typedef enum regIdT {
		idZero = 6'd32,	// Also what any unknown special id reads as
		idImm = 6'd33	// Lane immediate, sign extended
	} specialIdE;

	// Which bank holds the newest copy of a register
	typedef enum logic [1:0] {
		bankA = 2'd0,
		bankB = 2'd1,
		bankC = 2'd2
	} bankSelE;

	function automatic logic isArchId(regIdT id);
		return id < regIdT'(idZero);
	endfunction

endpackage

`default_nettype wire

// File: source/laneWriteIf.sv
`default_nettype none

// Results of one execute stage, all three lanes side by side
// Index 0 is lane A, 1 is lane B, 2 is lane C
interface laneWriteIf
	import gprSizePkg::*;
	import gprIdPkg::*;
();

	regIdT id [laneCount];		// Special id means no result on that lane
	regValueT value [laneCount];

	// Stage output side
	modport producer (
		output id,
		output value
	);

	// Banks and read ports
	modport consumer (
		input id,
		input value
	);

endinterface

`default_nettype wire

// File: source/gprBanks.sv
`default_nettype none

// Three single-writer banks plus a table naming the bank that is newest
module gprBanks
	import gprSizePkg::*;
	import gprIdPkg::*;
(
	input logic clock,
	input logic reset,
	input logic hold,
	input logic flush,
	laneWriteIf.consumer writeBack,
	input regIdT readIds [readPortCount],
	output regValueT archValues [readPortCount]
);

	logic writeEnable;
	logic [laneCount-1:0] laneWrite;
	regValueT bankRead [laneCount][readPortCount];
	bankSelE [gprCount-1:0] bankSel;

	assign writeEnable = !hold && !flush;

	for (genvar lane = 0; lane < laneCount; lane++) begin : bank
		regValueT mem [gprCount];	// Contents undefined until first write

		assign laneWrite[lane] = writeEnable && isArchId(writeBack.id[lane]);

		always_ff @(posedge clock) begin
			if (laneWrite[lane])
				mem[writeBack.id[lane][gprIndexWidth-1:0]] <= writeBack.value[lane];
		end

		// Every port looks into every bank, the select table picks later
		for (genvar port = 0; port < readPortCount; port++) begin : lookup
			assign bankRead[lane][port] = mem[readIds[port][gprIndexWidth-1:0]];
		end
	end

	// Later lanes are assigned last, so C beats B beats A on a clash
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int r = 0; r < gprCount; r++)
				bankSel[r] <= bankA;
		end else begin
			for (int lane = 0; lane < laneCount; lane++) begin
				if (laneWrite[lane])
					bankSel[writeBack.id[lane][gprIndexWidth-1:0]] <= bankSelE'(lane);
			end
		end
	end

	always_comb begin
		for (int port = 0; port < readPortCount; port++) begin
			case (bankSel[readIds[port][gprIndexWidth-1:0]])
				bankB: archValues[port] = bankRead[bankB][port];
				bankC: archValues[port] = bankRead[bankC][port];
				default: archValues[port] = bankRead[bankA][port];
			endcase
		end
	end

	// Encoding 3 would point past the last bank
	for (genvar r = 0; r < gprCount; r++) begin : selCheck
		assert property (@(posedge clock) disable iff (reset)
			bankSel[r] inside {bankA, bankB, bankC})
			else $error("Select entry %0d holds an unused encoding", r);
	end

	// Suppressed write-back must not move any register to another bank
	assert property (@(posedge clock) disable iff (reset)
		(hold || flush) |=> $stable(bankSel))
		else $error("Select table changed under hold or flush");

endmodule

`default_nettype wire

// File: source/gprReadPort.sv
`default_nettype none

// One operand: decode the id, then bypass from EX1 and EX2
module gprReadPort
	import gprSizePkg::*;
	import gprIdPkg::*;
(
	input regIdT readId,
	input immValueT laneImm,
	input regValueT archValue,	// Bank value for readId
	laneWriteIf.consumer ex1,
	laneWriteIf.consumer ex2,
	output regValueT operand
);

	logic isArch;
	logic [laneCount-1:0] ex1Hit;
	logic [laneCount-1:0] ex2Hit;
	regValueT decoded;
	regValueT immExtended;

	assign isArch = isArchId(readId);

	assign immExtended = {{(dataWidth-immWidth){laneImm[immWidth-1]}}, laneImm};

	always_comb begin
		if (isArch)
			decoded = archValue;
		else if (readId == idImm)
			decoded = immExtended;
		else
			decoded = '0;	// idZero and every unassigned special id
	end

	// Special ids never match, so zero and immediate are not bypassed
	always_comb begin
		for (int lane = 0; lane < laneCount; lane++) begin
			ex1Hit[lane] = isArch && (ex1.id[lane] == readId);
			ex2Hit[lane] = isArch && (ex2.id[lane] == readId);
		end
	end

	// Walked from lowest priority up
	// Last match assigned is EX1 lane A, which is the youngest result
	always_comb begin
		operand = decoded;
		for (int lane = laneCount - 1; lane >= 0; lane--) begin
			if (ex2Hit[lane])
				operand = ex2.value[lane];
		end
		for (int lane = laneCount - 1; lane >= 0; lane--) begin
			if (ex1Hit[lane])
				operand = ex1.value[lane];
		end
	end

endmodule

`default_nettype wire

// File: source/gprFile.sv
`default_nettype none

// Register file, six combinational reads and three write lanes
module gprFile
	import gprSizePkg::*;
	import gprIdPkg::*;
(
	input logic clock,
	input logic reset,
	input logic hold,		// Stalls write-back only
	input logic ex2Flush,

	input regIdT readIdRs,
	input regIdT readIdRt,
	input regIdT readIdRu,
	input regIdT readIdRv,
	input regIdT readIdRx,
	input regIdT readIdRy,
	output regValueT readValRs,
	output regValueT readValRt,
	output regValueT readValRu,
	output regValueT readValRv,
	output regValueT readValRx,
	output regValueT readValRy,

	input immValueT immLaneA,
	input immValueT immLaneB,
	input immValueT immLaneC,

	input regIdT ex1IdA,
	input regIdT ex1IdB,
	input regIdT ex1IdC,
	input regValueT ex1ValA,
	input regValueT ex1ValB,
	input regValueT ex1ValC,

	input regIdT ex2IdA,
	input regIdT ex2IdB,
	input regIdT ex2IdC,
	input regValueT ex2ValA,
	input regValueT ex2ValB,
	input regValueT ex2ValC
);

	regIdT readIds [readPortCount];
	regValueT archValues [readPortCount];
	regValueT operands [readPortCount];
	immValueT laneImms [laneCount];

	laneWriteIf ex1Bus ();	// Bypass only
	laneWriteIf ex2Bus ();	// Bypass and write-back

	assign ex1Bus.id[0] = ex1IdA;
	assign ex1Bus.id[1] = ex1IdB;
	assign ex1Bus.id[2] = ex1IdC;
	assign ex1Bus.value[0] = ex1ValA;
	assign ex1Bus.value[1] = ex1ValB;
	assign ex1Bus.value[2] = ex1ValC;

	assign ex2Bus.id[0] = ex2IdA;
	assign ex2Bus.id[1] = ex2IdB;
	assign ex2Bus.id[2] = ex2IdC;
	assign ex2Bus.value[0] = ex2ValA;
	assign ex2Bus.value[1] = ex2ValB;
	assign ex2Bus.value[2] = ex2ValC;

	// Port order Rs Rt Ru Rv Rx Ry, two per lane
	assign readIds = '{readIdRs, readIdRt, readIdRu, readIdRv, readIdRx, readIdRy};
	assign laneImms = '{immLaneA, immLaneB, immLaneC};

	gprBanks banks (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.flush(ex2Flush),
		.writeBack(ex2Bus),
		.readIds(readIds),
		.archValues(archValues)
	);

	for (genvar port = 0; port < readPortCount; port++) begin : readPort
		gprReadPort portDecode (
			.readId(readIds[port]),
			.laneImm(laneImms[port / (readPortCount / laneCount)]),
			.archValue(archValues[port]),
			.ex1(ex1Bus),
			.ex2(ex2Bus),
			.operand(operands[port])
		);
	end

	assign readValRs = operands[0];
	assign readValRt = operands[1];
	assign readValRu = operands[2];
	assign readValRv = operands[3];
	assign readValRx = operands[4];
	assign readValRy = operands[5];

endmodule

`default_nettype wire

// File: verif/gprFileTb.sv
`default_nettype none

module gprFileTb
	import gprSizePkg::*;
	import gprIdPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int rowMax = 128;
	localparam int randomRows = 60;
	localparam int resetCycles = 2;

	logic clock = 1'b0;
	logic reset;
	logic hold;
	logic ex2Flush;
	regIdT readIds [readPortCount];
	regValueT readVals [readPortCount];
	immValueT imms [laneCount];
	regIdT ex1Ids [laneCount];
	regValueT ex1Vals [laneCount];
	regIdT ex2Ids [laneCount];
	regValueT ex2Vals [laneCount];

	// Stimulus table, one row per cycle
	logic rowHold [rowMax];
	logic rowFlush [rowMax];
	regIdT rowEx1Id [rowMax][laneCount];
	regValueT rowEx1Val [rowMax][laneCount];
	regIdT rowEx2Id [rowMax][laneCount];
	regValueT rowEx2Val [rowMax][laneCount];
	regIdT rowReadId [rowMax][readPortCount];
	immValueT rowImm [rowMax][laneCount];
	regValueT rowExpect [rowMax][readPortCount];
	int rowCount = 0;

	int cycleCount = 0;
	int cycleLimit = rowMax + resetCycles + 20;	// Tightened once the table is built

	string portNames [readPortCount] = '{"readValRs", "readValRt", "readValRu",
		"readValRv", "readValRx", "readValRy"};

	gprFile uut (
		.clock(clock), .reset(reset), .hold(hold), .ex2Flush(ex2Flush),
		.readIdRs(readIds[0]), .readIdRt(readIds[1]), .readIdRu(readIds[2]),
		.readIdRv(readIds[3]), .readIdRx(readIds[4]), .readIdRy(readIds[5]),
		.readValRs(readVals[0]), .readValRt(readVals[1]), .readValRu(readVals[2]),
		.readValRv(readVals[3]), .readValRx(readVals[4]), .readValRy(readVals[5]),
		.immLaneA(imms[0]), .immLaneB(imms[1]), .immLaneC(imms[2]),
		.ex1IdA(ex1Ids[0]), .ex1IdB(ex1Ids[1]), .ex1IdC(ex1Ids[2]),
		.ex1ValA(ex1Vals[0]), .ex1ValB(ex1Vals[1]), .ex1ValC(ex1Vals[2]),
		.ex2IdA(ex2Ids[0]), .ex2IdB(ex2Ids[1]), .ex2IdC(ex2Ids[2]),
		.ex2ValA(ex2Vals[0]), .ex2ValB(ex2Vals[1]), .ex2ValC(ex2Vals[2])
	);

	always #2 clock = ~clock;

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: the vector table did not finish within %0d cycles", cycleLimit);
			$display("TB FAILED");
			$fatal(1, "Run stopped by cycle limit");
		end
	end

	task automatic checkValue(input string name, input regValueT actual,
			input regValueT expected);
		if (actual !== expected) begin
			$display("Fail %s actual %h expected %h", name, actual, expected);
			$display("TB FAILED");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	function automatic regValueT randomValue();
		return {$urandom, $urandom};
	endfunction

	// Mostly a small set of registers so bypass hits are common
	function automatic regIdT randomId();
		int pick;
		pick = $urandom_range(19, 0);
		if (pick < 16)
			return regIdT'(pick);
		else if (pick < 18)
			return idImm;
		return regIdT'(32 + $urandom_range(31, 0));
	endfunction

	// New idle row: no lane results, all ports read zero
	task automatic openRow(output int r);
		r = rowCount;
		rowCount++;
		rowHold[r] = 1'b0;
		rowFlush[r] = 1'b0;
		for (int l = 0; l < laneCount; l++) begin
			rowEx1Id[r][l] = idZero;
			rowEx2Id[r][l] = idZero;
			rowEx1Val[r][l] = randomValue();
			rowEx2Val[r][l] = randomValue();
			rowImm[r][l] = immValueT'(randomValue());
		end
		for (int p = 0; p < readPortCount; p++)
			rowReadId[r][p] = idZero;
	endtask

	task automatic buildDirected();
		int r;
		// Fill all 32 registers, lane order rotated each row
		for (int w = 0; w < 11; w++) begin
			openRow(r);
			for (int l = 0; l < laneCount; l++) begin
				rowEx2Id[r][l] = regIdT'(3 * w + (l + w) % 3);
				rowReadId[r][l] = rowEx2Id[r][l];	// Only visible through bypass yet
			end
			rowReadId[r][3] = idImm;
			rowReadId[r][5] = idImm;
		end
		openRow(r);	// Three lanes on one register
		rowEx2Id[r] = '{6'd5, 6'd5, 6'd5};
		rowReadId[r][0] = 6'd5;
		openRow(r);
		rowReadId[r] = '{6'd5, 6'd5, 6'd5, 6'd5, 6'd5, 6'd5};
		openRow(r);	// Lanes B and C clash
		rowEx2Id[r] = '{6'd9, 6'd7, 6'd7};
		openRow(r);
		rowReadId[r] = '{6'd7, 6'd9, 6'd7, 6'd9, 6'd7, 6'd9};
		for (int g = 0; g < gprCount; g++) begin
			openRow(r);
			for (int p = 0; p < readPortCount; p++)
				rowReadId[r][p] = regIdT'(g);
		end
		openRow(r);	// Write under hold
		rowHold[r] = 1'b1;
		rowEx2Id[r][1] = 6'd3;
		openRow(r);
		rowReadId[r] = '{6'd3, 6'd3, 6'd3, 6'd3, 6'd3, 6'd3};
		openRow(r);	// Write under flush
		rowFlush[r] = 1'b1;
		rowEx2Id[r] = '{6'd4, 6'd4, 6'd4};
		openRow(r);
		rowReadId[r] = '{6'd4, 6'd4, 6'd4, 6'd4, 6'd4, 6'd4};
		// Bypass order, one candidate fewer per row, all under hold
		for (int k = 0; k <= 2 * laneCount; k++) begin
			openRow(r);
			rowHold[r] = 1'b1;
			for (int l = 0; l < laneCount; l++) begin
				if (l >= k)
					rowEx1Id[r][l] = 6'd10;
				if (l + laneCount >= k)
					rowEx2Id[r][l] = 6'd10;
			end
			rowReadId[r] = '{6'd10, 6'd10, 6'd10, 6'd10, 6'd10, 6'd10};
		end
		openRow(r);	// Special ids, lanes carry the same ids
		rowEx1Id[r] = '{idImm, idZero, idImm};
		rowEx2Id[r] = '{idImm, 6'd40, idZero};
		rowReadId[r] = '{idImm, 6'd34, idImm, idZero, idImm, 6'd63};
		rowImm[r] = '{33'h1_0000_0001, 33'h0_ffff_ffff, 33'h1_8000_0000};
	endtask

	task automatic buildRandom();
		int r;
		for (int n = 0; n < randomRows; n++) begin
			openRow(r);
			rowHold[r] = ($urandom_range(3, 0) == 0);
			rowFlush[r] = ($urandom_range(3, 0) == 0);
			for (int l = 0; l < laneCount; l++) begin
				rowEx1Id[r][l] = randomId();
				rowEx2Id[r][l] = randomId();
			end
			for (int p = 0; p < readPortCount; p++)
				rowReadId[r][p] = randomId();
		end
	endtask

	// Reference model: shadow registers, bypass order, lane C wins on write
	task automatic computeExpected();
		regValueT shadow [gprCount];
		regIdT id;
		regIdT slotId;
		regValueT slotVal;
		logic found;
		for (int g = 0; g < gprCount; g++)
			shadow[g] = '0;
		for (int r = 0; r < rowCount; r++) begin
			for (int p = 0; p < readPortCount; p++) begin
				id = rowReadId[r][p];
				if (id == idImm)
					rowExpect[r][p] = regValueT'($signed(rowImm[r][p / 2]));
				else if (id >= 6'd32)
					rowExpect[r][p] = '0;
				else begin
					rowExpect[r][p] = shadow[id[4:0]];
					found = 1'b0;
					for (int s = 0; s < 2 * laneCount; s++) begin
						slotId = (s < laneCount) ? rowEx1Id[r][s] : rowEx2Id[r][s - laneCount];
						slotVal = (s < laneCount) ? rowEx1Val[r][s] : rowEx2Val[r][s - laneCount];
						if (!found && slotId == id) begin
							rowExpect[r][p] = slotVal;
							found = 1'b1;
						end
					end
				end
			end
			if (!rowHold[r] && !rowFlush[r]) begin
				for (int l = 0; l < laneCount; l++)
					if (rowEx2Id[r][l] < 6'd32)
						shadow[rowEx2Id[r][l][4:0]] = rowEx2Val[r][l];
			end
		end
	endtask

	task automatic driveRow(input int r);
		hold <= rowHold[r];
		ex2Flush <= rowFlush[r];
		for (int l = 0; l < laneCount; l++) begin
			ex1Ids[l] <= rowEx1Id[r][l];
			ex1Vals[l] <= rowEx1Val[r][l];
			ex2Ids[l] <= rowEx2Id[r][l];
			ex2Vals[l] <= rowEx2Val[r][l];
			imms[l] <= rowImm[r][l];
		end
		for (int p = 0; p < readPortCount; p++)
			readIds[p] <= rowReadId[r][p];
	endtask

	initial begin
		void'($urandom(32'h2a7f8009));
		reset = 1'b1;
		hold = 1'b0;
		ex2Flush = 1'b0;
		for (int l = 0; l < laneCount; l++) begin
			ex1Ids[l] = idZero;
			ex2Ids[l] = idZero;
			ex1Vals[l] = '0;
			ex2Vals[l] = '0;
			imms[l] = '0;
		end
		for (int p = 0; p < readPortCount; p++)
			readIds[p] = idZero;
		buildDirected();
		buildRandom();
		computeExpected();
		cycleLimit = rowCount + resetCycles + 20;
		repeat (resetCycles) @(posedge clock);
		reset <= 1'b0;
		for (int r = 0; r < rowCount; r++) begin
			@(posedge clock);
			driveRow(r);
			@(negedge clock);	// Reads are combinational, settled by mid cycle
			for (int p = 0; p < readPortCount; p++)
				checkValue($sformatf("%s row %0d", portNames[p], r), readVals[p],
					rowExpect[r][p]);
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: gprFile.f
source/gprSizePkg.sv
source/gprIdPkg.sv
source/laneWriteIf.sv
source/gprBanks.sv
source/gprReadPort.sv
source/gprFile.sv
verif/gprFileTb.sv

// File: run.sh
#!/bin/sh
# Builds the register file testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module gprFileTb \
	-f gprFile.f -Mdir obj_dir -o gprFileSim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/gprFileSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
	exit 0
else
	echo "Pass message not found in sim.log"
	exit 1
fi
